//--- core_isa_pkg.sv
// RV32 subset encodings
`default_nettype none

package core_isa_pkg;

	parameter int XLEN = 32;
	parameter int REG_ADDR_W = 5;

	// Major opcodes
	parameter logic [6:0] OPCODE_OP = 7'b0110011;
	parameter logic [6:0] OPCODE_OP_IMM = 7'b0010011;

	parameter logic [6:0] FUNCT7_BASE = 7'b0000000;
	parameter logic [6:0] FUNCT7_SUB = 7'b0100000;
	parameter logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	parameter logic [2:0] FUNCT3_ADD = 3'b000;
	parameter logic [2:0] FUNCT3_SLT = 3'b010;
	parameter logic [2:0] FUNCT3_XOR = 3'b100;
	parameter logic [2:0] FUNCT3_OR = 3'b110;
	parameter logic [2:0] FUNCT3_AND = 3'b111;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_MUL
	} alu_op_e;

endpackage

`default_nettype wire

//--- core_pipe_pkg.sv
// Pipeline stage payloads
`default_nettype none

package core_pipe_pkg;

	// Decode to execute latch contents
	typedef struct packed {
		core_isa_pkg::alu_op_e op;
		logic [core_isa_pkg::XLEN-1:0] op_a;
		logic [core_isa_pkg::XLEN-1:0] op_b;
		logic [core_isa_pkg::REG_ADDR_W-1:0] rd;
		logic we;
		logic is_mult;
	} exe_payload_t;

	// One multiply stage with the product already formed
	typedef struct packed {
		logic [core_isa_pkg::XLEN-1:0] product;
		logic [core_isa_pkg::REG_ADDR_W-1:0] rd;
		logic we;
	} mult_payload_t;

endpackage

`default_nettype wire

//--- pipe_stage_reg.sv
// Pipeline stage register
`timescale 1ns/1ps
`default_nettype none

module pipe_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     stall_i,
	input  logic     valid_i,
	input  payload_t data_i,
	output logic     valid_o,
	output payload_t data_o
);

	// A stalled upstream stage leaves a bubble behind
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i && !stall_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!stall_i) begin
			data_o <= data_i;
		end
	end

endmodule

`default_nettype wire

//--- decoder.sv
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  logic [core_isa_pkg::XLEN-1:0]       instr_i,
	output core_isa_pkg::alu_op_e               op_o,
	output logic [core_isa_pkg::REG_ADDR_W-1:0] rs1_o,
	output logic [core_isa_pkg::REG_ADDR_W-1:0] rs2_o,
	output logic [core_isa_pkg::REG_ADDR_W-1:0] rd_o,
	output logic                                use_rs2_o,
	output logic [core_isa_pkg::XLEN-1:0]       imm_o,
	output logic                                is_mult_o,
	output logic                                we_o,
	output logic                                illegal_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	assign rd_o = instr_i[11:7];
	assign rs1_o = instr_i[19:15];
	assign rs2_o = instr_i[24:20];
	assign imm_o = {{20{instr_i[31]}}, instr_i[31:20]};

	always_comb begin
		op_o = core_isa_pkg::ALU_ADD;
		use_rs2_o = 1'b0;
		is_mult_o = 1'b0;
		illegal_o = 1'b0;
		case (opcode)
			core_isa_pkg::OPCODE_OP: begin
				use_rs2_o = 1'b1;
				case ({funct7, funct3})
					{core_isa_pkg::FUNCT7_BASE, core_isa_pkg::FUNCT3_ADD}: op_o = core_isa_pkg::ALU_ADD;
					{core_isa_pkg::FUNCT7_SUB, core_isa_pkg::FUNCT3_ADD}: op_o = core_isa_pkg::ALU_SUB;
					{core_isa_pkg::FUNCT7_BASE, core_isa_pkg::FUNCT3_AND}: op_o = core_isa_pkg::ALU_AND;
					{core_isa_pkg::FUNCT7_BASE, core_isa_pkg::FUNCT3_OR}: op_o = core_isa_pkg::ALU_OR;
					{core_isa_pkg::FUNCT7_BASE, core_isa_pkg::FUNCT3_XOR}: op_o = core_isa_pkg::ALU_XOR;
					{core_isa_pkg::FUNCT7_BASE, core_isa_pkg::FUNCT3_SLT}: op_o = core_isa_pkg::ALU_SLT;
					{core_isa_pkg::FUNCT7_MULDIV, core_isa_pkg::FUNCT3_ADD}: begin
						op_o = core_isa_pkg::ALU_MUL;
						is_mult_o = 1'b1;
					end
					default: illegal_o = 1'b1;
				endcase
			end
			// Only ADDI in the immediate group
			core_isa_pkg::OPCODE_OP_IMM: illegal_o = funct3 != core_isa_pkg::FUNCT3_ADD;
			default: illegal_o = 1'b1;
		endcase
	end

	// x0 is never a destination
	assign we_o = !illegal_o && rd_o != '0;

endmodule

`default_nettype wire

//--- int_registers.sv
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module int_registers (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  logic [core_isa_pkg::REG_ADDR_W-1:0] read_addr_a_i,
	input  logic [core_isa_pkg::REG_ADDR_W-1:0] read_addr_b_i,
	output logic [core_isa_pkg::XLEN-1:0]       read_data_a_o,
	output logic [core_isa_pkg::XLEN-1:0]       read_data_b_o,
	input  logic [core_isa_pkg::REG_ADDR_W-1:0] write_addr_i,
	input  logic [core_isa_pkg::XLEN-1:0]       write_data_i,
	input  logic                                write_enable_i
);

	logic [core_isa_pkg::XLEN-1:0] regs [32];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable_i && write_addr_i != '0) begin
			regs[write_addr_i] <= write_data_i;
		end
	end

	// Combinational read with x0 hardwired to zero
	assign read_data_a_o = (read_addr_a_i == '0) ? '0 : regs[read_addr_a_i];
	assign read_data_b_o = (read_addr_b_i == '0) ? '0 : regs[read_addr_b_i];

endmodule

`default_nettype wire

//--- bypass_ctrl.sv
// Operand bypass and issue stall
`timescale 1ns/1ps
`default_nettype none

module bypass_ctrl #(
	parameter int MULT_STAGES = 5
) (
	input  logic [core_isa_pkg::REG_ADDR_W-1:0]                  dec_rs1_i,
	input  logic [core_isa_pkg::REG_ADDR_W-1:0]                  dec_rs2_i,
	input  logic                                                 dec_use_rs2_i,
	input  logic                                                 dec_is_mult_i,
	input  logic [core_isa_pkg::XLEN-1:0]                        reg_data_a_i,
	input  logic [core_isa_pkg::XLEN-1:0]                        reg_data_b_i,
	input  logic                                                 exe_valid_i,
	input  logic                                                 exe_is_mult_i,
	input  logic [core_isa_pkg::REG_ADDR_W-1:0]                  exe_rd_i,
	input  logic [core_isa_pkg::XLEN-1:0]                        exe_result_i,
	input  logic [MULT_STAGES-1:0]                               mult_valid_i,
	input  logic [MULT_STAGES-1:0][core_isa_pkg::REG_ADDR_W-1:0] mult_rd_i,
	input  logic                                                 wb_we_i,
	input  logic [core_isa_pkg::REG_ADDR_W-1:0]                  wb_rd_i,
	input  logic [core_isa_pkg::XLEN-1:0]                        wb_data_i,
	output logic [core_isa_pkg::XLEN-1:0]                        op_a_o,
	output logic [core_isa_pkg::XLEN-1:0]                        op_b_o,
	output logic                                                 stall_o
);

	logic exe_hit_a;
	logic exe_hit_b;
	logic wb_hit_a;
	logic wb_hit_b;
	logic mult_busy;
	logic hazard_a;
	logic hazard_b;

	// x0 never forwards and reads zero from the file
	assign exe_hit_a = exe_valid_i && !exe_is_mult_i && dec_rs1_i != '0 && exe_rd_i == dec_rs1_i;
	assign exe_hit_b = exe_valid_i && !exe_is_mult_i && dec_rs2_i != '0 && exe_rd_i == dec_rs2_i;
	assign wb_hit_a = wb_we_i && dec_rs1_i != '0 && wb_rd_i == dec_rs1_i;
	assign wb_hit_b = wb_we_i && dec_rs2_i != '0 && wb_rd_i == dec_rs2_i;

	assign op_a_o = exe_hit_a ? exe_result_i : (wb_hit_a ? wb_data_i : reg_data_a_i);
	assign op_b_o = exe_hit_b ? exe_result_i : (wb_hit_b ? wb_data_i : reg_data_b_i);

	// Multiply results only forward once they reach write-back
	always_comb begin
		mult_busy = exe_valid_i && exe_is_mult_i;
		hazard_a = mult_busy && exe_rd_i == dec_rs1_i;
		hazard_b = mult_busy && exe_rd_i == dec_rs2_i;
		for (int i = 0; i < MULT_STAGES; i++) begin
			mult_busy = mult_busy || mult_valid_i[i];
			hazard_a = hazard_a || (mult_valid_i[i] && mult_rd_i[i] == dec_rs1_i);
			hazard_b = hazard_b || (mult_valid_i[i] && mult_rd_i[i] == dec_rs2_i);
		end
		hazard_a = hazard_a && dec_rs1_i != '0;
		hazard_b = hazard_b && dec_use_rs2_i && dec_rs2_i != '0;
		// Non-multiplies wait for the multiply chain to drain so write-back stays in order
		stall_o = hazard_a || hazard_b || (mult_busy && !dec_is_mult_i);
	end

endmodule

`default_nettype wire

//--- int_alu.sv
// Integer ALU
`timescale 1ns/1ps
`default_nettype none

module int_alu (
	input  core_isa_pkg::alu_op_e         op_i,
	input  logic [core_isa_pkg::XLEN-1:0] a_i,
	input  logic [core_isa_pkg::XLEN-1:0] b_i,
	output logic [core_isa_pkg::XLEN-1:0] result_o
);

	always_comb begin
		case (op_i)
			core_isa_pkg::ALU_ADD: result_o = a_i + b_i;
			core_isa_pkg::ALU_SUB: result_o = a_i - b_i;
			core_isa_pkg::ALU_AND: result_o = a_i & b_i;
			core_isa_pkg::ALU_OR: result_o = a_i | b_i;
			core_isa_pkg::ALU_XOR: result_o = a_i ^ b_i;
			core_isa_pkg::ALU_SLT: begin
				result_o = '0;
				result_o[0] = $signed(a_i) < $signed(b_i);
			end
			// MUL goes through the multiply chain
			default: result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- mult_pipe.sv
// Pipelined multiplier
`timescale 1ns/1ps
`default_nettype none

module mult_pipe #(
	parameter int MULT_STAGES = 5
) (
	input  logic                                                 clk_i,
	input  logic                                                 rst_i,
	input  logic                                                 valid_i,
	input  logic [core_isa_pkg::XLEN-1:0]                        a_i,
	input  logic [core_isa_pkg::XLEN-1:0]                        b_i,
	input  logic [core_isa_pkg::REG_ADDR_W-1:0]                  rd_i,
	input  logic                                                 we_i,
	output logic [MULT_STAGES-1:0]                               stage_valid_o,
	output logic [MULT_STAGES-1:0][core_isa_pkg::REG_ADDR_W-1:0] stage_rd_o,
	output logic                                                 valid_o,
	output logic [core_isa_pkg::REG_ADDR_W-1:0]                  rd_o,
	output logic [core_isa_pkg::XLEN-1:0]                        result_o
);

	logic [core_isa_pkg::XLEN-1:0] product_lo;
	core_pipe_pkg::mult_payload_t head;
	core_pipe_pkg::mult_payload_t [MULT_STAGES-1:0] stage_data;

	// Low word of the product
	assign product_lo = a_i * b_i;
	assign head = '{product: product_lo, rd: rd_i, we: we_i};

	for (genvar i = 0; i < MULT_STAGES; i++) begin : g_stage
		core_pipe_pkg::mult_payload_t in_data;
		logic in_valid;

		if (i == 0) begin : g_head
			assign in_valid = valid_i;
			assign in_data = head;
		end else begin : g_link
			assign in_valid = stage_valid_o[i-1];
			assign in_data = stage_data[i-1];
		end

		pipe_stage_reg #(
			.payload_t(core_pipe_pkg::mult_payload_t)
		) stage_reg_i (
			.clk_i   (clk_i),
			.rst_i   (rst_i),
			.stall_i (1'b0),
			.valid_i (in_valid),
			.data_i  (in_data),
			.valid_o (stage_valid_o[i]),
			.data_o  (stage_data[i])
		);

		assign stage_rd_o[i] = stage_data[i].rd;
	end

	// Writes to x0 leave the chain silently
	assign valid_o = stage_valid_o[MULT_STAGES-1] && stage_data[MULT_STAGES-1].we;
	assign rd_o = stage_data[MULT_STAGES-1].rd;
	assign result_o = stage_data[MULT_STAGES-1].product;

endmodule

`default_nettype wire

//--- exec_core.sv
// Integer execute core
`timescale 1ns/1ps
`default_nettype none

module exec_core #(
	parameter int MULT_STAGES = 5
) (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  logic                                instr_valid_i,
	input  logic [core_isa_pkg::XLEN-1:0]       instr_i,
	output logic                                instr_ready_o,
	output logic                                wb_valid_o,
	output logic [core_isa_pkg::REG_ADDR_W-1:0] wb_addr_o,
	output logic [core_isa_pkg::XLEN-1:0]       wb_data_o
);

	// Decode
	core_isa_pkg::alu_op_e dec_op;
	logic [core_isa_pkg::REG_ADDR_W-1:0] dec_rs1;
	logic [core_isa_pkg::REG_ADDR_W-1:0] dec_rs2;
	logic [core_isa_pkg::REG_ADDR_W-1:0] dec_rd;
	logic dec_use_rs2;
	logic [core_isa_pkg::XLEN-1:0] dec_imm;
	logic dec_is_mult;
	logic dec_we;
	logic dec_illegal;
	logic [core_isa_pkg::XLEN-1:0] reg_data_a;
	logic [core_isa_pkg::XLEN-1:0] reg_data_b;
	logic [core_isa_pkg::XLEN-1:0] op_a;
	logic [core_isa_pkg::XLEN-1:0] op_b;
	logic stall;
	core_pipe_pkg::exe_payload_t dec_payload;

	// Execute
	logic exe_valid;
	core_pipe_pkg::exe_payload_t exe_payload;
	logic [core_isa_pkg::XLEN-1:0] alu_result;
	logic [MULT_STAGES-1:0] mult_stage_valid;
	logic [MULT_STAGES-1:0][core_isa_pkg::REG_ADDR_W-1:0] mult_stage_rd;
	logic mult_valid;
	logic [core_isa_pkg::REG_ADDR_W-1:0] mult_rd;
	logic [core_isa_pkg::XLEN-1:0] mult_result;

	// Write-back latch
	logic wb_valid;
	logic [core_isa_pkg::REG_ADDR_W-1:0] wb_addr;
	logic [core_isa_pkg::XLEN-1:0] wb_data;

	decoder decoder_i (
		.instr_i   (instr_i),
		.op_o      (dec_op),
		.rs1_o     (dec_rs1),
		.rs2_o     (dec_rs2),
		.rd_o      (dec_rd),
		.use_rs2_o (dec_use_rs2),
		.imm_o     (dec_imm),
		.is_mult_o (dec_is_mult),
		.we_o      (dec_we),
		.illegal_o (dec_illegal)
	);

	int_registers int_registers_i (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.read_addr_a_i  (dec_rs1),
		.read_addr_b_i  (dec_rs2),
		.read_data_a_o  (reg_data_a),
		.read_data_b_o  (reg_data_b),
		.write_addr_i   (wb_addr),
		.write_data_i   (wb_data),
		.write_enable_i (wb_valid)
	);

	bypass_ctrl #(
		.MULT_STAGES(MULT_STAGES)
	) bypass_ctrl_i (
		.dec_rs1_i     (dec_rs1),
		.dec_rs2_i     (dec_rs2),
		.dec_use_rs2_i (dec_use_rs2),
		.dec_is_mult_i (dec_is_mult),
		.reg_data_a_i  (reg_data_a),
		.reg_data_b_i  (reg_data_b),
		.exe_valid_i   (exe_valid),
		.exe_is_mult_i (exe_payload.is_mult),
		.exe_rd_i      (exe_payload.rd),
		.exe_result_i  (alu_result),
		.mult_valid_i  (mult_stage_valid),
		.mult_rd_i     (mult_stage_rd),
		.wb_we_i       (wb_valid),
		.wb_rd_i       (wb_addr),
		.wb_data_i     (wb_data),
		.op_a_o        (op_a),
		.op_b_o        (op_b),
		.stall_o       (stall)
	);

	assign instr_ready_o = !stall;

	always_comb begin
		dec_payload.op = dec_op;
		dec_payload.op_a = op_a;
		dec_payload.op_b = dec_use_rs2 ? op_b : dec_imm;
		dec_payload.rd = dec_rd;
		dec_payload.we = dec_we;
		dec_payload.is_mult = dec_is_mult;
	end

	// Illegal words never enter the pipeline
	pipe_stage_reg #(
		.payload_t(core_pipe_pkg::exe_payload_t)
	) dec_exe (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.stall_i (stall),
		.valid_i (instr_valid_i && !dec_illegal),
		.data_i  (dec_payload),
		.valid_o (exe_valid),
		.data_o  (exe_payload)
	);

	int_alu int_alu_i (
		.op_i     (exe_payload.op),
		.a_i      (exe_payload.op_a),
		.b_i      (exe_payload.op_b),
		.result_o (alu_result)
	);

	mult_pipe #(
		.MULT_STAGES(MULT_STAGES)
	) mult_pipe_i (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.valid_i       (exe_valid && exe_payload.is_mult),
		.a_i           (exe_payload.op_a),
		.b_i           (exe_payload.op_b),
		.rd_i          (exe_payload.rd),
		.we_i          (exe_payload.we),
		.stage_valid_o (mult_stage_valid),
		.stage_rd_o    (mult_stage_rd),
		.valid_o       (mult_valid),
		.rd_o          (mult_rd),
		.result_o      (mult_result)
	);

	// The issue stall keeps ALU and multiply results from arriving together
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= mult_valid || (exe_valid && !exe_payload.is_mult && exe_payload.we);
		end
	end

	always_ff @(posedge clk_i) begin
		if (mult_valid) begin
			wb_addr <= mult_rd;
			wb_data <= mult_result;
		end else begin
			wb_addr <= exe_payload.rd;
			wb_data <= alu_result;
		end
	end

	assign wb_valid_o = wb_valid;
	assign wb_addr_o = wb_addr;
	assign wb_data_o = wb_data;

endmodule

`default_nettype wire

//--- exec_core_assert.sv
// Execute core assertions
`timescale 1ns/1ps
`default_nettype none

module exec_core_assert #(
	parameter int MULT_STAGES = 5
) (
	input logic                                clk_i,
	input logic                                rst_i,
	input logic                                instr_ready_i,
	input logic                                wb_valid_i,
	input logic [core_isa_pkg::REG_ADDR_W-1:0] wb_addr_i,
	input logic                                exe_valid_i,
	input logic                                exe_is_mult_i,
	input logic [MULT_STAGES-1:0]              mult_stage_valid_i
);

	logic mult_in_flight;

	assign mult_in_flight = (exe_valid_i && exe_is_mult_i) || (|mult_stage_valid_i);

	// x0 is never a write-back target
	wb_addr_nonzero: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_valid_i |-> wb_addr_i != '0)
		else $error("write-back addressed x0");

	wb_idle_after_reset: assert property (@(posedge clk_i) rst_i |=> !wb_valid_i)
		else $error("write-back valid in the cycle after reset");

	// Every stall rule needs a multiply somewhere in the pipeline
	ready_low_cause: assert property (@(posedge clk_i) disable iff (rst_i)
		!instr_ready_i |-> mult_in_flight)
		else $error("issue stalled with no multiply in flight");

endmodule

bind exec_core exec_core_assert #(
	.MULT_STAGES(MULT_STAGES)
) exec_core_assert_i (
	.clk_i              (clk_i),
	.rst_i              (rst_i),
	.instr_ready_i      (instr_ready_o),
	.wb_valid_i         (wb_valid_o),
	.wb_addr_i          (wb_addr_o),
	.exe_valid_i        (exe_valid),
	.exe_is_mult_i      (exe_payload.is_mult),
	.mult_stage_valid_i (mult_stage_valid)
);

`default_nettype wire

//--- tb_exec_core.sv
// Execute core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;

	localparam int MULT_STAGES = 5;
	localparam int ALU_LATENCY = 2;
	localparam int MUL_LATENCY = MULT_STAGES + 2;
	localparam int STALL_LIMIT = 4 * MULT_STAGES + 10;
	localparam int DRAIN_LIMIT = 4 * MULT_STAGES + 20;

	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB = 7'b0100000;
	localparam logic [6:0] F7_MUL = 7'b0000001;
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	logic clk;
	logic rst;
	logic instr_valid;
	logic [31:0] instr;
	logic instr_ready;
	logic wb_valid;
	logic [4:0] wb_addr;
	logic [31:0] wb_data;

	logic [31:0] lfsr;
	logic [31:0] model_regs [32];
	logic [4:0] exp_rd [$];
	logic [31:0] exp_data [$];
	int exp_due [$];
	int cycle_count;
	int errors;
	int checks;
	int stall_cycles;
	int wb_events;
	int pushes;
	int peak_outstanding;
	int tests_run;
	int tests_passed;
	int tests_failed;
	int test_first_error;
	string test_name;

	exec_core #(
		.MULT_STAGES(MULT_STAGES)
	) exec_core_i (
		.clk_i         (clk),
		.rst_i         (rst),
		.instr_valid_i (instr_valid),
		.instr_i       (instr),
		.instr_ready_o (instr_ready),
		.wb_valid_o    (wb_valid),
		.wb_addr_o     (wb_addr),
		.wb_data_o     (wb_data)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] enc_addi(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [4:0] rd);
		return {imm, rs1, F3_ADD, rd, OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] enc_alu(input logic [2:0] sel, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		case (sel)
			3'd1, 3'd7: return enc_r(F7_SUB, F3_ADD, rd, rs1, rs2);
			3'd2: return enc_r(F7_BASE, F3_AND, rd, rs1, rs2);
			3'd3: return enc_r(F7_BASE, F3_OR, rd, rs1, rs2);
			3'd4: return enc_r(F7_BASE, F3_XOR, rd, rs1, rs2);
			3'd5: return enc_r(F7_BASE, F3_SLT, rd, rs1, rs2);
			default: return enc_r(F7_BASE, F3_ADD, rd, rs1, rs2);
		endcase
	endfunction

	task automatic note_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("Timeout: %s", reason);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	// Architectural result of one accepted word in program order
	task automatic model_accept(input logic [31:0] word);
		logic [4:0] rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic legal;
		int lat;
		rd = word[11:7];
		a = model_regs[word[19:15]];
		b = model_regs[word[24:20]];
		legal = 1'b1;
		lat = ALU_LATENCY;
		res = '0;
		if (word[6:0] == OPC_OP_IMM && word[14:12] == F3_ADD) begin
			res = a + {{20{word[31]}}, word[31:20]};
		end else if (word[6:0] == OPC_OP) begin
			case ({word[31:25], word[14:12]})
				{F7_BASE, F3_ADD}: res = a + b;
				{F7_SUB, F3_ADD}: res = a - b;
				{F7_BASE, F3_AND}: res = a & b;
				{F7_BASE, F3_OR}: res = a | b;
				{F7_BASE, F3_XOR}: res = a ^ b;
				{F7_BASE, F3_SLT}: res = {31'b0, $signed(a) < $signed(b)};
				{F7_MUL, F3_ADD}: begin
					res = a * b;
					lat = MUL_LATENCY;
				end
				default: legal = 1'b0;
			endcase
		end else begin
			legal = 1'b0;
		end
		if (legal && rd != 5'd0) begin
			model_regs[rd] = res;
			exp_rd.push_back(rd);
			exp_data.push_back(res);
			exp_due.push_back(cycle_count + lat);
			pushes++;
			if (exp_data.size() > peak_outstanding) begin
				peak_outstanding = exp_data.size();
			end
		end
	endtask

	task automatic check_writeback();
		logic [4:0] rd;
		logic [31:0] data;
		int due;
		wb_events++;
		if (exp_data.size() == 0) begin
			note_failure($sformatf("Unexpected write-back to x%0d with no result pending", wb_addr));
		end else begin
			rd = exp_rd.pop_front();
			data = exp_data.pop_front();
			due = exp_due.pop_front();
			check_hex("wb_addr_o", {27'b0, wb_addr}, {27'b0, rd});
			check_hex("wb_data_o", wb_data, data);
			check_hex("write-back cycle", cycle_count, due);
		end
	endtask

	// Inputs and outputs are both settled at the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			if (wb_valid) begin
				check_writeback();
			end
			if (instr_valid && instr_ready) begin
				model_accept(instr);
			end
			if (instr_valid && !instr_ready) begin
				stall_cycles++;
			end
		end
	end

	task automatic issue(input logic [31:0] word);
		int waited;
		waited = 0;
		instr_valid <= 1'b1;
		instr <= word;
		@(negedge clk);
		while (!instr_ready && waited < STALL_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!instr_ready) begin
			abort_run("instruction was not accepted before the stall limit");
		end else begin
			@(posedge clk);
		end
	endtask

	task automatic drain_pipeline();
		int waited;
		waited = 0;
		instr_valid <= 1'b0;
		@(posedge clk);
		while (exp_data.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_data.size() != 0) begin
			abort_run("results were still pending after the drain limit");
		end else begin
			// Quiet cycles catch stray write-backs
			repeat (3) @(posedge clk);
		end
	endtask

	task automatic seed_low_regs();
		logic [31:0] r;
		for (int i = 1; i < 8; i++) begin
			take_bits(12, r);
			issue(enc_addi(r[11:0], 5'd0, i[4:0]));
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_first_error = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == test_first_error) begin
			tests_passed++;
			$display("Test %0d %s: passed", tests_run, test_name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed with %0d errors", tests_run, test_name,
				errors - test_first_error);
		end
	endtask

	task automatic test_reset_addi();
		logic [31:0] r;
		begin_test("reset and ADDI");
		@(negedge clk);
		check_hex("wb_valid_o", {31'b0, wb_valid}, 32'd0);
		check_hex("instr_ready_o", {31'b0, instr_ready}, 32'd1);
		@(posedge clk);
		// Each register copied onto itself must come back zero
		for (int i = 1; i < 32; i++) begin
			issue(enc_addi(12'h000, i[4:0], i[4:0]));
		end
		for (int i = 0; i < 12; i++) begin
			take_bits(17, r);
			issue(enc_addi(r[16:5], 5'd0, r[4:0]));
		end
		drain_pipeline();
		end_test();
	endtask

	task automatic test_alu_forwarding();
		logic [31:0] r;
		int stalls_before;
		begin_test("ALU forwarding");
		seed_low_regs();
		stalls_before = stall_cycles;
		for (int i = 0; i < 40; i++) begin
			take_bits(12, r);
			issue(enc_alu(r[11:9], {2'b00, r[8:6]}, {2'b00, r[5:3]}, {2'b00, r[2:0]}));
		end
		checks++;
		if (stall_cycles != stalls_before) begin
			note_failure("ALU-only program stalled the issue port");
		end
		drain_pipeline();
		end_test();
	endtask

	task automatic test_mul_burst();
		logic [31:0] r;
		int stalls_before;
		begin_test("independent MUL burst");
		seed_low_regs();
		stalls_before = stall_cycles;
		peak_outstanding = 0;
		for (int i = 0; i < 8; i++) begin
			take_bits(6, r);
			issue(enc_r(F7_MUL, F3_ADD, {2'b01, i[2:0]}, {2'b00, r[5:3]}, {2'b00, r[2:0]}));
		end
		checks++;
		if (stall_cycles != stalls_before) begin
			note_failure("independent MUL burst stalled the issue port");
		end
		check_hex("peak results in flight", peak_outstanding, MUL_LATENCY);
		drain_pipeline();
		end_test();
	endtask

	task automatic test_mul_hazards();
		logic [31:0] r;
		logic [4:0] mul_rd;
		logic [4:0] next_rd;
		int stalls_before;
		begin_test("MUL hazards");
		for (int i = 0; i < 12; i++) begin
			take_bits(5, r);
			mul_rd = {2'b01, r[2:0]};
			next_rd = {2'b10, r[2:0]};
			stalls_before = stall_cycles;
			issue(enc_r(F7_MUL, F3_ADD, mul_rd, 5'd1, 5'd2));
			case (r[4:3])
				2'd0: issue(enc_r(F7_BASE, F3_ADD, next_rd, mul_rd, 5'd3));
				2'd1: issue(enc_r(F7_BASE, F3_XOR, next_rd, 5'd4, 5'd5));
				2'd2: issue(enc_r(F7_MUL, F3_ADD, next_rd, mul_rd, 5'd2));
				default: issue(enc_r(F7_MUL, F3_ADD, next_rd, 5'd3, 5'd4));
			endcase
			checks++;
			if (r[4:3] == 2'd3 && stall_cycles != stalls_before) begin
				note_failure("independent MUL after MUL was stalled");
			end else if (r[4:3] != 2'd3 && stall_cycles == stalls_before) begin
				note_failure("instruction behind a MUL was issued without a stall");
			end
		end
		drain_pipeline();
		end_test();
	endtask

	task automatic test_silent_words();
		int events_before;
		int pushes_before;
		begin_test("illegal words and x0 writes");
		events_before = wb_events;
		pushes_before = pushes;
		issue(32'hffff_ffff);
		issue(enc_addi(12'h7ff, 5'd1, 5'd0));
		issue(enc_r(F7_SUB, F3_AND, 5'd6, 5'd1, 5'd2));
		issue({12'h003, 5'd1, 3'b001, 5'd7, OPC_OP_IMM});
		issue(enc_r(F7_BASE, F3_ADD, 5'd0, 5'd1, 5'd2));
		issue(enc_r(F7_MUL, 3'b100, 5'd6, 5'd1, 5'd2));
		issue(32'h0000_0000);
		issue(enc_r(F7_MUL, F3_ADD, 5'd0, 5'd3, 5'd4));
		issue(enc_r(F7_BASE, F3_ADD, 5'd20, 5'd0, 5'd1));
		issue(enc_r(F7_SUB, F3_ADD, 5'd21, 5'd6, 5'd7));
		issue(enc_addi(12'h123, 5'd20, 5'd22));
		drain_pipeline();
		check_hex("write-back count", wb_events - events_before, pushes - pushes_before);
		end_test();
	endtask

	task automatic test_mixed_program();
		logic [31:0] r;
		logic [31:0] k;
		begin_test("long mixed program");
		for (int i = 0; i < 200; i++) begin
			take_bits(3, k);
			take_bits(15, r);
			case (k[2:0])
				3'd4: issue(enc_addi(r[14:3], {1'b0, r[3:0]}, {1'b0, r[7:4]}));
				3'd5: issue(enc_r(F7_MUL, F3_ADD, {1'b0, r[3:0]}, {1'b0, r[7:4]},
					{1'b0, r[11:8]}));
				3'd6: begin
					take_bits(32, r);
					issue(r);
				end
				3'd7: issue(enc_alu(r[14:12], 5'd0, {1'b0, r[7:4]}, {1'b0, r[11:8]}));
				default: issue(enc_alu(r[14:12], {1'b0, r[3:0]}, {1'b0, r[7:4]},
					{1'b0, r[11:8]}));
			endcase
		end
		drain_pipeline();
		end_test();
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		lfsr = 32'h8b7294c5;
		cycle_count = 0;
		errors = 0;
		checks = 0;
		stall_cycles = 0;
		wb_events = 0;
		pushes = 0;
		peak_outstanding = 0;
		tests_run = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		test_reset_addi();
		test_alu_forwarding();
		test_mul_burst();
		test_mul_hazards();
		test_silent_words();
		test_mixed_program();

		$display("Tests run %0d, passed %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_passed, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- exec_core.f
core_isa_pkg.sv
core_pipe_pkg.sv
pipe_stage_reg.sv
decoder.sv
int_registers.sv
bypass_ctrl.sv
int_alu.sv
mult_pipe.sv
exec_core.sv
exec_core_assert.sv
tb_exec_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_exec_core -f exec_core.f -o sim_exec_core
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_exec_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# A failed assertion stops the run with an error line
if grep -q "%Error" sim.log; then
	exit 1
fi
if grep -qx "SIMULATION PASSED" sim.log; then
	exit 0
fi
exit 1
